// File: tests/prog_input.hex
// program bytes from 0x0000, little endian, load data at 0x0200
// expected stores at 0xF000: addr_lo addr_hi data 01 per record, list ends with 00 00 00 FF
@0000
13 01 00 30  // addi x2, x0, 0x300
93 02 C0 F9  // addi x5, x0, -100
13 03 30 00  // addi x6, x0, 3
B3 83 62 40  // sub x7, x5, x6
33 D4 62 40  // sra x8, x5, x6
93 D4 22 40  // srai x9, x5, 2
23 20 71 00  // sw x7, 0(x2)
23 22 81 00  // sw x8, 4(x2)
23 24 91 00  // sw x9, 8(x2)
B3 A5 62 00  // slt x11, x5, x6
33 B6 62 00  // sltu x12, x5, x6
93 36 F3 FF  // sltiu x13, x6, -1
13 97 25 00  // slli x14, x11, 2
93 17 16 00  // slli x15, x12, 1
33 67 F7 00  // or x14, x14, x15
33 67 D7 00  // or x14, x14, x13
13 47 07 7A  // xori x14, x14, 0x7a0
23 26 E1 00  // sw x14, 12(x2)
33 D8 62 00  // srl x16, x5, x6
B3 78 58 00  // and x17, x16, x5
B3 88 68 00  // add x17, x17, x6
23 28 01 01  // sw x16, 16(x2)
23 2A 11 01  // sw x17, 20(x2)
37 39 12 80  // lui x18, 0x80123
97 19 00 00  // auipc x19, 0x1
13 09 F9 FF  // addi x18, x18, -1
23 2C 21 01  // sw x18, 24(x2)
23 2E 31 01  // sw x19, 28(x2)
63 04 63 00  // beq x6, x6, +8 taken
A3 0F 51 06  // sb x5, 127(x2) skipped
63 84 62 00  // beq x5, x6, +8 not taken
13 65 15 00  // ori x10, x10, 1
63 94 62 00  // bne x5, x6, +8 taken
A3 0F 51 06  // sb x5, 127(x2) skipped
63 14 63 00  // bne x6, x6, +8 not taken
13 65 25 00  // ori x10, x10, 2
63 C4 62 00  // blt x5, x6, +8 taken
A3 0F 51 06  // sb x5, 127(x2) skipped
63 44 53 00  // blt x6, x5, +8 not taken
13 65 45 00  // ori x10, x10, 4
63 54 53 00  // bge x6, x5, +8 taken
A3 0F 51 06  // sb x5, 127(x2) skipped
63 D4 62 00  // bge x5, x6, +8 not taken
13 65 85 00  // ori x10, x10, 8
63 64 53 00  // bltu x6, x5, +8 taken
A3 0F 51 06  // sb x5, 127(x2) skipped
63 E4 62 00  // bltu x5, x6, +8 not taken
13 65 05 01  // ori x10, x10, 16
63 F4 62 00  // bgeu x5, x6, +8 taken
A3 0F 51 06  // sb x5, 127(x2) skipped
63 74 53 00  // bgeu x6, x5, +8 not taken
13 65 05 02  // ori x10, x10, 32
23 20 A1 02  // sw x10, 32(x2)
6F 0A 80 00  // jal x20, +8
A3 0F 51 06  // sb x5, 127(x2) skipped
E7 0A DA 00  // jalr x21, 13(x20), lands on 0xe4
A3 0F 51 06  // sb x5, 127(x2) skipped
23 22 41 03  // sw x20, 36(x2)
23 24 51 03  // sw x21, 40(x2)
93 01 00 20  // addi x3, x0, 0x200
03 8B 01 00  // lb x22, 0(x3)
83 CB 01 00  // lbu x23, 0(x3)
03 9C 01 00  // lh x24, 0(x3)
83 DC 21 00  // lhu x25, 2(x3)
03 AD 01 00  // lw x26, 0(x3)
23 26 61 03  // sw x22, 44(x2)
23 28 71 03  // sw x23, 48(x2)
23 2A 81 03  // sw x24, 52(x2)
23 2C 91 03  // sw x25, 56(x2)
23 2E A1 03  // sw x26, 60(x2)
23 00 A1 05  // sb x26, 64(x2)
23 11 A1 05  // sh x26, 66(x2)
6F 00 00 00  // jal x0, 0
@0200
85 96 A7 F8  // load data word 0xf8a79685
@F000
00 03 99 01  01 03 FF 01  02 03 FF 01  03 03 FF 01  // sub -103
04 03 F3 01  05 03 FF 01  06 03 FF 01  07 03 FF 01  // sra -13
08 03 E7 01  09 03 FF 01  0A 03 FF 01  0B 03 FF 01  // srai -25
0C 03 A5 01  0D 03 07 01  0E 03 00 01  0F 03 00 01  // slt, sltu, sltiu, xori
10 03 F3 01  11 03 FF 01  12 03 FF 01  13 03 1F 01  // srl
14 03 93 01  15 03 FF 01  16 03 FF 01  17 03 1F 01  // and, add
18 03 FF 01  19 03 2F 01  1A 03 12 01  1B 03 80 01  // lui, addi
1C 03 60 01  1D 03 10 01  1E 03 00 01  1F 03 00 01  // auipc
20 03 3F 01  21 03 00 01  22 03 00 01  23 03 00 01  // not taken path marks
24 03 D8 01  25 03 00 01  26 03 00 01  27 03 00 01  // jal link
28 03 E0 01  29 03 00 01  2A 03 00 01  2B 03 00 01  // jalr link
2C 03 85 01  2D 03 FF 01  2E 03 FF 01  2F 03 FF 01  // lb
30 03 85 01  31 03 00 01  32 03 00 01  33 03 00 01  // lbu
34 03 85 01  35 03 96 01  36 03 FF 01  37 03 FF 01  // lh
38 03 A7 01  39 03 F8 01  3A 03 00 01  3B 03 00 01  // lhu
3C 03 85 01  3D 03 96 01  3E 03 A7 01  3F 03 F8 01  // lw
40 03 85 01  42 03 85 01  43 03 96 01              // sb, sh
00 00 00 FF                                         // end of list

// File: filelist.f
common/retro_pkg.sv
hw/fetch/fetch_seq.sv
hw/decode/inst_decoder.sv
hw/reg_file.sv
hw/execute/exec_unit.sv
hw/mem/lsu.sv
hw/retro_top.sv
tests/tb_clock.sv
tests/retro_tb.sv

// File: tests/retro_tb.sv
// Retro core testbench
`timescale 1ns/10ps

module retro_tb;

  localparam int          addr_width = 16;
  localparam logic [31:0] start_addr = 32'h0000_0000;
  localparam int          rec_base   = 'hF000; // expected store list in the image
  localparam int          max_recs   = 1024;

  logic                  clk;
  logic                  rst_n;
  logic                  hold;
  logic [7:0]            data_in;
  logic [addr_width-1:0] address;
  logic [7:0]            data_out;
  logic                  wren;

  logic [7:0]  mem [0:(1<<addr_width)-1];
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  int          n_rec;
  int          rec_idx;
  int          errors;
  int          cycles;
  int          cycle_limit;
  int          burst;

  tb_clock #(
    .period       (8.0),
    .reset_cycles (2)
  ) u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  retro_top #(
    .addr_width (addr_width),
    .start_addr (start_addr)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .hold     (hold),
    .data_in  (data_in),
    .address  (address),
    .data_out (data_out),
    .wren     (wren)
  );

  assign data_in = mem[address]; // asynchronous read

  // each record is addr_lo addr_hi data marker
  // marker 01 marks a record and FF ends the list
  task automatic read_expected();
    int base;
    begin
      n_rec = 0;
      base  = rec_base;
      while (n_rec < max_recs && mem[base + 3] === 8'h01) begin
        exp_addr.push_back({mem[base + 1], mem[base]});
        exp_data.push_back(mem[base + 2]);
        n_rec++;
        base += 4;
      end
      assert (mem[base + 3] === 8'hFF) else begin
        errors++;
        $display("the expected store list in the data file has no terminator");
      end
    end
  endtask

  initial begin
    errors  = 0;
    rec_idx = 0;
    cycles  = 0;
    $readmemh("tests/prog_input.hex", mem);
    read_expected();
    cycle_limit = 64 * n_rec + 400;
    @(posedge rst_n);
    @(negedge clk);
    assert (address == start_addr[addr_width-1:0] && wren == 1'b0) else begin
      errors++;
      $display("Error at %0t: after reset address %h wren %b, expected %h and 0",
               $time, address, wren, start_addr[addr_width-1:0]);
    end
    wait (rec_idx == n_rec);
    @(negedge clk);
    $display("%0d errors in %0d stores", errors, n_rec);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // hold driven in random bursts 1 ns after the rising edge
  initial begin
    hold  = 1'b0;
    burst = 0;
    void'($urandom(23581));
    forever begin
      @(posedge clk);
      #1;
      if (burst > 0) begin
        hold = 1'b1;
        burst--;
      end else if ($urandom % 6 == 0) begin
        hold  = 1'b1;
        burst = $urandom % 4;
      end else begin
        hold = 1'b0;
      end
    end
  end

  // store bytes compared mid cycle on a settled bus
  always @(negedge clk) begin
    if (rst_n && wren) begin
      assert (rec_idx < n_rec) else begin
        errors++;
        $display("the core wrote %h to %h after the last expected store", data_out, address);
      end
      if (rec_idx < n_rec) begin
        assert (address == exp_addr[rec_idx] && data_out == exp_data[rec_idx]) else begin
          errors++;
          $display("Error at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                   rec_idx, data_out, address, exp_data[rec_idx], exp_addr[rec_idx]);
        end
        rec_idx++;
      end
      mem[address] = data_out;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("the program did not finish within %0d cycles, %0d of %0d stores seen",
               cycle_limit, rec_idx, n_rec);
      $display("%0d errors in %0d stores", errors + 1, n_rec);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

// File: tests/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock #(
  parameter real period       = 8.0,
  parameter int  reset_cycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1; // release just after an edge
  end

endmodule

// File: hw/retro_top.sv
// Byte serial RV32I core top
`timescale 1ns/10ps

module retro_top import retro_pkg::*; #(
  parameter int          addr_width = 16,
  parameter logic [31:0] start_addr = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hold,       // freezes the whole core
  input  logic [7:0]            data_in,
  output logic [addr_width-1:0] address,
  output logic [7:0]            data_out,
  output logic                  wren
);

  logic [addr_width-1:0] pc_addr;
  xlen_t                 inst_word;
  xlen_t                 inst_pc;
  logic                  inst_valid;
  reg_idx_t              rs1_idx;
  reg_idx_t              rs2_idx;
  xlen_t                 rs1_data;
  xlen_t                 rs2_data;
  dec_inst_t             dec;
  logic                  dec_valid;
  wb_t                   exec_wb;
  wb_t                   load_wb;
  redirect_t             redirect;
  mem_req_t              mem_req;
  logic                  mem_valid;
  logic                  busy;

  fetch_seq #(
    .addr_width (addr_width),
    .start_addr (start_addr)
  ) u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .data_in    (data_in),
    .busy       (busy),
    .redirect   (redirect),
    .pc_addr    (pc_addr),
    .inst_word  (inst_word),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid)
  );

  inst_decoder u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .inst_word  (inst_word),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rs1_idx    (rs1_idx),
    .rs2_idx    (rs2_idx),
    .dec        (dec),
    .dec_valid  (dec_valid)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .exec_wb  (exec_wb),
    .load_wb  (load_wb),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit u_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .dec       (dec),
    .dec_valid (dec_valid),
    .exec_wb   (exec_wb),
    .redirect  (redirect),
    .mem_req   (mem_req),
    .mem_valid (mem_valid)
  );

  lsu #(
    .addr_width (addr_width)
  ) u_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .data_in   (data_in),
    .pc_addr   (pc_addr),
    .mem_req   (mem_req),
    .mem_valid (mem_valid),
    .address   (address),
    .data_out  (data_out),
    .wren      (wren),
    .busy      (busy),
    .load_wb   (load_wb)
  );

endmodule

// File: hw/mem/lsu.sv
// Byte serial load/store unit
`timescale 1ns/10ps

module lsu import retro_pkg::*; #(
  parameter int addr_width = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hold,
  input  logic [7:0]            data_in,
  input  logic [addr_width-1:0] pc_addr,
  input  mem_req_t              mem_req,
  input  logic                  mem_valid,
  output logic [addr_width-1:0] address,
  output logic [7:0]            data_out,
  output logic                  wren,
  output logic                  busy,
  output wb_t                   load_wb
);

  mem_req_t              req;     // request being served
  logic [1:0]            cnt;     // byte number within the transfer
  logic [1:0]            last;
  xlen_t                 acc;
  xlen_t                 shifted;
  xlen_t                 load_val;
  logic [addr_width-1:0] xfer_addr;

  always_comb begin
    case (req.size)
      sz_byte: last = 2'd0;
      sz_half: last = 2'd1;
      default: last = 2'd3;
    endcase
  end

  // new byte enters at the top, so after N bytes the value is in the upper N bytes
  assign shifted = {data_in, acc[31:8]};

  always_comb begin
    case (req.size)
      sz_byte: load_val = {{24{!req.is_unsigned && shifted[31]}}, shifted[31:24]};
      sz_half: load_val = {{16{!req.is_unsigned && shifted[31]}}, shifted[31:16]};
      default: load_val = shifted;
    endcase
  end

  assign xfer_addr = req.addr[addr_width-1:0] + addr_width'(cnt);
  assign address   = busy ? xfer_addr : pc_addr;
  assign data_out  = req.data[8*cnt +: 8];  // lsb first
  assign wren      = busy && req.is_store && !hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      cnt     <= 2'd0;
      load_wb <= '0;
    end else if (!hold) begin
      load_wb.we <= 1'b0;
      if (mem_valid) begin
        busy <= 1'b1;
        cnt  <= 2'd0;
      end else if (busy) begin
        if (cnt == last) begin
          busy <= 1'b0;
          if (!req.is_store) begin
            load_wb.we    <= 1'b1;
            load_wb.rd    <= req.rd;
            load_wb.value <= load_val;
          end
        end else begin
          cnt <= cnt + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      if (mem_valid) begin
        req <= mem_req;
      end else if (busy && !req.is_store) begin
        acc <= shifted;
      end
    end
  end

endmodule

// File: hw/execute/exec_unit.sv
// Execute stage
`timescale 1ns/10ps

module exec_unit import retro_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  dec_inst_t dec,
  input  logic      dec_valid,
  output wb_t       exec_wb,
  output redirect_t redirect,
  output mem_req_t  mem_req,
  output logic      mem_valid
);

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_res;
  logic       cond;
  xlen_t      target;
  xlen_t      wb_value;
  logic       writes_rd;
  logic       is_mem;

  assign op_a  = dec.rs1_val;
  assign op_b  = (dec.cls == cls_alu_reg) ? dec.rs2_val : dec.imm;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.funct3)
      3'b000:  alu_res = (dec.cls == cls_alu_reg && dec.alt) ? op_a - op_b : op_a + op_b;
      3'b001:  alu_res = op_a << shamt;
      3'b010:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      3'b011:  alu_res = xlen_t'(op_a < op_b);
      3'b100:  alu_res = op_a ^ op_b;
      3'b101:  alu_res = dec.alt ? xlen_t'($signed(op_a) >>> shamt) : op_a >> shamt;
      3'b110:  alu_res = op_a | op_b;
      default: alu_res = op_a & op_b;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = dec.rs1_val == dec.rs2_val;
      3'b001:  cond = dec.rs1_val != dec.rs2_val;
      3'b100:  cond = $signed(dec.rs1_val) < $signed(dec.rs2_val);
      3'b101:  cond = $signed(dec.rs1_val) >= $signed(dec.rs2_val);
      3'b110:  cond = dec.rs1_val < dec.rs2_val;
      3'b111:  cond = dec.rs1_val >= dec.rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign target = (dec.cls == cls_jalr) ? dec.rs1_val + dec.imm : dec.pc + dec.imm;

  always_comb begin
    writes_rd = 1'b1;
    case (dec.cls)
      cls_lui:            wb_value = dec.imm;
      cls_auipc:          wb_value = dec.pc + dec.imm;
      cls_jal, cls_jalr:  wb_value = dec.pc + 32'd4; // link
      cls_alu_imm, cls_alu_reg: wb_value = alu_res;
      default: begin
        wb_value  = alu_res;
        writes_rd = 1'b0;
      end
    endcase
  end

  assign is_mem = (dec.cls == cls_load) || (dec.cls == cls_store);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec_wb   <= '0;
      redirect  <= '0;
      mem_req   <= '0;
      mem_valid <= 1'b0;
    end else if (!hold) begin
      exec_wb.we      <= dec_valid && writes_rd;
      exec_wb.rd      <= dec.rd;
      exec_wb.value   <= wb_value;
      redirect.taken  <= dec_valid && (dec.cls == cls_jal || dec.cls == cls_jalr ||
                                       (dec.cls == cls_branch && cond));
      redirect.target <= {target[31:1], 1'b0};
      mem_valid       <= dec_valid && is_mem;
      mem_req.is_store    <= dec.cls == cls_store;
      mem_req.size        <= mem_size_t'(dec.funct3[1:0]);
      mem_req.is_unsigned <= dec.funct3[2]; // lbu, lhu
      mem_req.addr        <= dec.rs1_val + dec.imm;
      mem_req.data        <= dec.rs2_val;
      mem_req.rd          <= dec.rd;
    end
  end

endmodule

// File: hw/reg_file.sv
// Integer register file
`timescale 1ns/10ps

module reg_file import retro_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  wb_t      exec_wb,
  input  wb_t      load_wb,
  output xlen_t    rs1_data,
  output xlen_t    rs2_data
);

  xlen_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (exec_wb.we && exec_wb.rd != '0) begin
      regs[exec_wb.rd] <= exec_wb.value;
    end else if (load_wb.we && load_wb.rd != '0) begin
      regs[load_wb.rd] <= load_wb.value;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: hw/decode/inst_decoder.sv
// Instruction decoder
`timescale 1ns/10ps

module inst_decoder import retro_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  xlen_t     inst_word,
  input  xlen_t     inst_pc,
  input  logic      inst_valid,
  input  xlen_t     rs1_data,
  input  xlen_t     rs2_data,
  output reg_idx_t  rs1_idx,
  output reg_idx_t  rs2_idx,
  output dec_inst_t dec,
  output logic      dec_valid
);

  logic [6:0] opcode;
  op_class_t  cls;
  xlen_t      imm;
  reg_idx_t   rd;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  assign opcode  = inst_word[6:0];
  assign rs1_idx = inst_word[19:15];
  assign rs2_idx = inst_word[24:20];

  // immediates of every format
  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                  inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u = {inst_word[31:12], 12'b0};
  assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                  inst_word[20], inst_word[30:21], 1'b0};

  always_comb begin
    cls = cls_nop;
    imm = '0;
    rd  = inst_word[11:7];
    case (opcode)
      opc_lui: begin
        cls = cls_lui;
        imm = imm_u;
      end
      opc_auipc: begin
        cls = cls_auipc;
        imm = imm_u;
      end
      opc_jal: begin
        cls = cls_jal;
        imm = imm_j;
      end
      opc_jalr: begin
        cls = cls_jalr;
        imm = imm_i;
      end
      opc_branch: begin
        cls = cls_branch;
        imm = imm_b;
        rd  = '0;  // no register result
      end
      opc_load: begin
        cls = cls_load;
        imm = imm_i;
      end
      opc_store: begin
        cls = cls_store;
        imm = imm_s;
        rd  = '0;
      end
      opc_op_imm: begin
        cls = cls_alu_imm;
        imm = imm_i; // shamt sits in imm[4:0]
      end
      opc_op: begin
        cls = cls_alu_reg;
      end
      opc_misc_mem: begin
        rd = '0;     // fence
      end
      default: begin
        rd = '0;     // unknown opcode, nop
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (!hold) begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold && inst_valid) begin
      dec.cls     <= cls;
      dec.funct3  <= inst_word[14:12];
      dec.alt     <= inst_word[30];
      dec.rd      <= rd;
      dec.rs1_val <= rs1_data;
      dec.rs2_val <= rs2_data;
      dec.imm     <= imm;
      dec.pc      <= inst_pc;
    end
  end

endmodule

// File: hw/fetch/fetch_seq.sv
// Instruction fetch sequencer
`timescale 1ns/10ps

module fetch_seq import retro_pkg::*; #(
  parameter int          addr_width = 16,
  parameter logic [31:0] start_addr = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hold,
  input  logic [7:0]            data_in,
  input  logic                  busy,       // lsu owns the bus
  input  redirect_t             redirect,
  output logic [addr_width-1:0] pc_addr,
  output xlen_t                 inst_word,
  output xlen_t                 inst_pc,
  output logic                  inst_valid
);

  xlen_t      pc;        // address of byte 0 of the word in progress
  logic [1:0] phase;     // byte within the word
  xlen_t      byte_addr;
  logic       capture;

  assign byte_addr = pc + xlen_t'(phase);
  assign pc_addr   = byte_addr[addr_width-1:0];

  // a byte is taken only when the bus carries our address
  assign capture = !hold && !busy && !redirect.taken;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= start_addr;
      phase      <= 2'd0;
      inst_valid <= 1'b0;
    end else if (!hold) begin
      inst_valid <= 1'b0;
      if (redirect.taken) begin
        pc    <= redirect.target; // partial word is dropped
        phase <= 2'd0;
      end else if (busy) begin
        phase <= 2'd0;            // refetch this word once the transfer ends
      end else if (phase == 2'd3) begin
        pc         <= pc + 32'd4;
        phase      <= 2'd0;
        inst_valid <= 1'b1;
      end else begin
        phase <= phase + 2'd1;
      end
    end
  end

  // little endian, byte 0 ends up in bits 7:0
  always_ff @(posedge clk) begin
    if (capture) begin
      inst_word <= {data_in, inst_word[31:8]};
      if (phase == 2'd3) begin
        inst_pc <= pc;
      end
    end
  end

endmodule

// File: common/retro_pkg.sv
// Retro core shared types
package retro_pkg;

  localparam int xlen = 32; // machine word width
  localparam int reg_idx_w = 5; // register index width

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // major opcodes, instruction bits 6:0
  localparam logic [6:0] opc_lui      = 7'b0110111;
  localparam logic [6:0] opc_auipc    = 7'b0010111;
  localparam logic [6:0] opc_jal      = 7'b1101111;
  localparam logic [6:0] opc_jalr     = 7'b1100111;
  localparam logic [6:0] opc_branch   = 7'b1100011;
  localparam logic [6:0] opc_load     = 7'b0000011;
  localparam logic [6:0] opc_store    = 7'b0100011;
  localparam logic [6:0] opc_op_imm   = 7'b0010011;
  localparam logic [6:0] opc_op       = 7'b0110011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111; // fence, runs as nop

  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_alu_imm,
    cls_alu_reg,
    cls_nop
  } op_class_t;

  // transfer size, same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2
  } mem_size_t;

  typedef struct packed {
    op_class_t  cls;
    logic [2:0] funct3;
    logic       alt;     // inst bit 30
    reg_idx_t   rd;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    xlen_t      imm;     // sign extended
    xlen_t      pc;
  } dec_inst_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    xlen_t    value;
  } wb_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } redirect_t;

  typedef struct packed {
    logic      is_store;
    mem_size_t size;
    logic      is_unsigned;
    xlen_t     addr;   // effective byte address
    xlen_t     data;   // store data
    reg_idx_t  rd;     // load destination
  } mem_req_t;

endpackage
